/* source/fcvt_pkg.sv */
`default_nettype none

package fcvt_pkg;

    // Rounding mode encoding, matches the rmode field used by the producer
    typedef enum logic [1:0] {
        // Nearest, ties go to the even integer
        RM_RNE = 2'd0,
        // Toward zero, plain truncation
        RM_RTZ = 2'd1,
        // Toward plus infinity
        RM_RUP = 2'd2,
        // Toward minus infinity
        RM_RDN = 2'd3
    } rmode_e;

    // Progress of one four-phase transfer
    typedef enum logic {
        // Nothing in flight
        HS_IDLE      = 1'b0,
        // Own signal raised, partner must drop its side
        HS_WAIT_DROP = 1'b1
    } hs_state_e;

    // Integer returned for NaN, infinity and out of range operands.
    // Same bit pattern as the most negative valid result.
    localparam logic [31:0] INT_INVALID = 32'h8000_0000;

endpackage

`default_nettype wire

/* source/fcvt_in_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fcvt_in_port import fcvt_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_req,
    input  logic [31:0] in_op,
    input  rmode_e      in_rmode,
    output logic        in_ack,
    input  logic        buf_take,
    output logic        buf_valid,
    output logic [31:0] buf_op,
    output rmode_e      buf_rmode
);

    hs_state_e state;

    // New operand only when nothing is held, otherwise back-pressure
    logic accept;

    assign accept = (state == HS_IDLE) && in_req && !buf_valid;

    // Ack is high for the whole wait for req to fall
    assign in_ack = (state == HS_WAIT_DROP);

    // Receiver side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (accept) begin
                        state <= HS_WAIT_DROP;
                    end
                end
                HS_WAIT_DROP: begin
                    // Producer saw ack and released req
                    if (!in_req) begin
                        state <= HS_IDLE;
                    end
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

    // Occupancy flag of the single entry
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (accept) begin
            buf_valid <= 1'b1;
        end else if (buf_take) begin
            // Output side has registered the result
            buf_valid <= 1'b0;
        end
    end

    // Payload, only written on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_op    <= in_op;
            buf_rmode <= in_rmode;
        end
    end

endmodule

`default_nettype wire

/* source/float_to_int.sv */
`timescale 1ns/1ps
`default_nettype none

module float_to_int import fcvt_pkg::*; (
    input  logic [31:0] op,
    input  rmode_e      rmode,
    output logic [31:0] res,
    output logic        invalid,
    output logic        inexact
);

    // Raw fields
    logic        sign;
    logic [7:0]  exp_part;
    logic [22:0] fract_part;

    // Unbiased exponent, range -127..128
    logic signed [8:0] exponent;
    logic signed [8:0] shift_full;

    // Classification
    logic is_zero;
    logic is_subnormal;
    logic is_special;
    logic is_min_int;
    logic too_big;
    logic too_small;

    // Alignment, binary point between bit 32 and bit 31
    logic [63:0] fixed;
    logic [31:0] trunc;
    logic        guard;
    logic        sticky;
    logic        round_inc;
    logic [32:0] rounded;
    logic        out_of_range;

    assign sign       = op[31];
    assign exp_part   = op[30:23];
    assign fract_part = op[22:0];

    assign exponent   = $signed({1'b0, exp_part}) - 9'sd127;
    // sig * 2^(e-23) scaled by 2^32 means a left shift by e+9
    assign shift_full = exponent + 9'sd9;

    assign is_zero      = (exp_part == 8'd0) && (fract_part == 23'd0);
    assign is_subnormal = (exp_part == 8'd0) && (fract_part != 23'd0);
    assign is_special   = (exp_part == 8'hff);
    // Exactly -2^31, the only legal value with exponent 31
    assign is_min_int   = sign && (exp_part == 8'd158) && (fract_part == 23'd0);
    assign too_big      = (exponent >= 9'sd31);
    // Below 2^-9 every significand bit lands under the guard position
    assign too_small    = (exponent < -9'sd9);

    // Significand with hidden bit, shift of 0..39 keeps it inside 64 bits
    assign fixed = too_small ? 64'd0 : ({40'd0, 1'b1, fract_part} << shift_full[5:0]);

    assign trunc  = fixed[63:32];
    assign guard  = fixed[31];
    // Tiny values are nonzero but never reach the guard bit
    assign sticky = too_small ? 1'b1 : |fixed[30:0];

    // Increment per rounding mode
    always_comb begin
        case (rmode)
            RM_RNE:  round_inc = guard & (sticky | trunc[0]);
            RM_RTZ:  round_inc = 1'b0;
            RM_RUP:  round_inc = !sign & (guard | sticky);
            RM_RDN:  round_inc = sign & (guard | sticky);
            default: round_inc = 1'b0;
        endcase
    end

    assign rounded = {1'b0, trunc} + {32'd0, round_inc};

    // Positive limit 2^31-1, negative limit 2^31
    assign out_of_range = sign ? (rounded > 33'h0_8000_0000) : (rounded > 33'h0_7fff_ffff);

    // Special cases first, then the rounded value with its sign
    always_comb begin
        res     = 32'd0;
        invalid = 1'b0;
        inexact = 1'b0;
        if (is_zero) begin
            res = 32'd0;
        end else if (is_subnormal) begin
            // Flushed to zero, value was lost
            inexact = 1'b1;
        end else if (is_special) begin
            res     = INT_INVALID;
            invalid = 1'b1;
        end else if (is_min_int) begin
            res = INT_INVALID;
        end else if (too_big || out_of_range) begin
            res     = INT_INVALID;
            invalid = 1'b1;
        end else begin
            res     = sign ? (32'd0 - rounded[31:0]) : rounded[31:0];
            inexact = guard | sticky;
        end
    end

endmodule

`default_nettype wire

/* source/fcvt_out_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fcvt_out_port import fcvt_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        buf_valid,
    input  logic [31:0] conv_res,
    input  logic        conv_invalid,
    input  logic        conv_inexact,
    output logic        buf_take,
    output logic        out_req,
    output logic [31:0] out_res,
    output logic        out_invalid,
    output logic        out_inexact,
    input  logic        out_ack
);

    hs_state_e state;

    // Take a new result only with the sender idle and ack released
    assign buf_take = (state == HS_IDLE) && !out_ack && buf_valid;

    // Sender side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= HS_IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (buf_take) begin
                        state   <= HS_WAIT_DROP;
                        out_req <= 1'b1;
                    end
                end
                HS_WAIT_DROP: begin
                    if (out_req) begin
                        // Consumer has the data
                        if (out_ack) begin
                            out_req <= 1'b0;
                        end
                    end else if (!out_ack) begin
                        // Return to zero complete
                        state <= HS_IDLE;
                    end
                end
                default: begin
                    state   <= HS_IDLE;
                    out_req <= 1'b0;
                end
            endcase
        end
    end

    // Result and flags held stable while out_req is up
    always_ff @(posedge clk) begin
        if (buf_take) begin
            out_res     <= conv_res;
            out_invalid <= conv_invalid;
            out_inexact <= conv_inexact;
        end
    end

endmodule

`default_nettype wire

/* source/fcvt_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fcvt_top import fcvt_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_req,
    input  logic [31:0] in_op,
    input  rmode_e      in_rmode,
    output logic        in_ack,
    output logic        out_req,
    output logic [31:0] out_res,
    output logic        out_invalid,
    output logic        out_inexact,
    input  logic        out_ack
);

    // Held operand toward the converter
    logic        buf_valid;
    logic        buf_take;
    logic [31:0] buf_op;
    rmode_e      buf_rmode;

    // Converter outputs, valid whenever the buffer is full
    logic [31:0] conv_res;
    logic        conv_invalid;
    logic        conv_inexact;

    // Receiver with one-entry buffer
    fcvt_in_port u_in_port (
        .clk       (clk),
        .rst       (rst),
        .in_req    (in_req),
        .in_op     (in_op),
        .in_rmode  (in_rmode),
        .in_ack    (in_ack),
        .buf_take  (buf_take),
        .buf_valid (buf_valid),
        .buf_op    (buf_op),
        .buf_rmode (buf_rmode)
    );

    // Purely combinational path between the two ports
    float_to_int u_conv (
        .op      (buf_op),
        .rmode   (buf_rmode),
        .res     (conv_res),
        .invalid (conv_invalid),
        .inexact (conv_inexact)
    );

    // Result register and sender
    fcvt_out_port u_out_port (
        .clk          (clk),
        .rst          (rst),
        .buf_valid    (buf_valid),
        .conv_res     (conv_res),
        .conv_invalid (conv_invalid),
        .conv_inexact (conv_inexact),
        .buf_take     (buf_take),
        .out_req      (out_req),
        .out_res      (out_res),
        .out_invalid  (out_invalid),
        .out_inexact  (out_inexact),
        .out_ack      (out_ack)
    );

endmodule

`default_nettype wire

/* bench/fcvt_model.svh */
`ifndef FCVT_MODEL_SVH
`define FCVT_MODEL_SVH

// Expected converter response
typedef struct packed {
    logic [31:0] res;
    logic        invalid;
    logic        inexact;
} conv_t;

// Reference conversion, works by shifting the significand right
function automatic conv_t fcvt_ref(input logic [31:0] op, input rmode_e mode);
    conv_t       r;
    logic        neg;
    int          e;
    int          drop;
    logic [63:0] mant;
    logic [63:0] kept;
    logic [63:0] rest;
    logic        half;
    logic        below;
    logic        inc;
    logic [63:0] mag;
    r.res     = 32'd0;
    r.invalid = 1'b0;
    r.inexact = 1'b0;
    neg  = op[31];
    e    = int'(op[30:23]) - 127;
    mant = {40'd0, 1'b1, op[22:0]};
    // Zero of either sign
    if (op[30:0] == 31'd0) return r;
    // Subnormal flushed
    if (op[30:23] == 8'd0) begin
        r.inexact = 1'b1;
        return r;
    end
    // Inf, NaN, exact -2^31, then exponents too large
    if (op[30:23] == 8'hff || (e >= 31 && op != 32'hcf00_0000)) begin
        r.res     = INT_INVALID;
        r.invalid = 1'b1;
        return r;
    end
    if (op == 32'hcf00_0000) begin
        r.res = INT_INVALID;
        return r;
    end
    if (e >= 23) begin
        // Integer already, nothing dropped
        kept  = mant << (e - 23);
        half  = 1'b0;
        below = 1'b0;
    end else begin
        drop = 23 - e;
        if (drop > 24) begin
            // Whole significand under the half position
            kept  = 64'd0;
            half  = 1'b0;
            below = 1'b1;
        end else begin
            kept  = mant >> drop;
            half  = mant[drop - 1];
            rest  = mant & ((64'd1 << (drop - 1)) - 64'd1);
            below = (rest != 64'd0);
        end
    end
    case (mode)
        RM_RNE:  inc = half && (below || kept[0]);
        RM_RUP:  inc = !neg && (half || below);
        RM_RDN:  inc = neg && (half || below);
        default: inc = 1'b0;
    endcase
    mag = kept + {63'd0, inc};
    if ((!neg && mag > 64'h7fff_ffff) || (neg && mag > 64'h8000_0000)) begin
        r.res     = INT_INVALID;
        r.invalid = 1'b1;
        return r;
    end
    r.res     = neg ? (32'd0 - mag[31:0]) : mag[31:0];
    r.inexact = half || below;
    return r;
endfunction

`endif

/* bench/fcvt_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fcvt_tb import fcvt_pkg::*; ();

    localparam int N_DIR   = 32;
    localparam int N_RAND  = 2000;
    localparam int N_OPS   = N_DIR * 4 + N_RAND;
    // 40 cycles of 20 ns per operation
    localparam longint TIMEOUT_NS = longint'(N_OPS) * 40 * 20;

    `include "fcvt_model.svh"

    typedef struct packed {
        logic [31:0] op;
        rmode_e      mode;
        conv_t       conv;
    } exp_t;

    logic        clk;
    logic        rst;
    logic        in_req;
    logic [31:0] in_op;
    rmode_e      in_rmode;
    logic        in_ack;
    logic        out_req;
    logic [31:0] out_res;
    logic        out_invalid;
    logic        out_inexact;
    logic        out_ack;

    // Expected entries in send order, received results in arrival order
    exp_t        exp_q[$];
    conv_t       rx_q[$];
    int          num_checked;
    logic [31:0] prod_seed;
    logic [31:0] cons_seed;
    logic [31:0] cur_op;
    rmode_e      cur_mode;

    fcvt_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .in_req      (in_req),
        .in_op       (in_op),
        .in_rmode    (in_rmode),
        .in_ack      (in_ack),
        .out_req     (out_req),
        .out_res     (out_res),
        .out_invalid (out_invalid),
        .out_inexact (out_inexact),
        .out_ack     (out_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Mostly short waits, every eighth one long
    function automatic int unsigned pick_delay();
        cons_seed = lcg_step(cons_seed);
        if (cons_seed[29:27] == 3'd0) return int'(cons_seed[20:16]);
        return int'(cons_seed[17:16]);
    endfunction

    function automatic logic [31:0] directed_op(input int idx);
        case (idx)
            // Exact integers 1.0, -7.0, 2^30, then the ties 1.5 and -1.5
            0: return 32'h3f80_0000;
            1: return 32'hc0e0_0000;
            2: return 32'h4e80_0000;
            3: return 32'h3fc0_0000;
            4: return 32'hbfc0_0000;
            // Ties 2.5, 3.5, 0.5 and their negatives
            5: return 32'h4020_0000;
            6: return 32'hc020_0000;
            7: return 32'h4060_0000;
            8: return 32'hc060_0000;
            9: return 32'h3f00_0000;
            10: return 32'hbf00_0000;
            // Non-ties 1.25, 1.75
            11: return 32'h3fa0_0000;
            12: return 32'hbfa0_0000;
            13: return 32'h3fe0_0000;
            14: return 32'hbfe0_0000;
            // Zeros and subnormals
            15: return 32'h0000_0000;
            16: return 32'h8000_0000;
            17: return 32'h0000_0001;
            18: return 32'h807f_ffff;
            // Infinities, quiet and signaling NaN
            19: return 32'h7f80_0000;
            20: return 32'hff80_0000;
            21: return 32'h7fc0_0000;
            22: return 32'h7f80_0001;
            // -2^31, +2^31, 3e9
            23: return 32'hcf00_0000;
            24: return 32'h4f00_0000;
            25: return 32'h4f32_d05e;
            // Just past each end of the range
            26: return 32'h4f00_0001;
            27: return 32'hcf00_0001;
            // Largest magnitudes that still fit
            28: return 32'h4eff_ffff;
            29: return 32'hceff_ffff;
            // Just below 0.5, largest finite
            30: return 32'h3eff_ffff;
            default: return 32'h7f7f_ffff;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h (op %h mode %0d)",
                     name, got, exp, cur_op, cur_mode);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // Producer side of the input handshake
    task automatic send_op(input logic [31:0] op, input rmode_e mode);
        exp_t e;
        e.op   = op;
        e.mode = mode;
        e.conv = fcvt_ref(op, mode);
        exp_q.push_back(e);
        in_op    = op;
        in_rmode = mode;
        in_req   = 1'b1;
        do @(negedge clk); while (!in_ack);
        in_req = 1'b0;
        while (in_ack) @(negedge clk);
    endtask

    // Consumer with random ack timing
    initial begin
        conv_t got;
        out_ack   = 1'b0;
        cons_seed = lcg_step(32'heb58e2c3);
        forever begin
            @(negedge clk);
            if (out_req) begin
                got.res     = out_res;
                got.invalid = out_invalid;
                got.inexact = out_inexact;
                rx_q.push_back(got);
                repeat (pick_delay()) @(negedge clk);
                out_ack = 1'b1;
                do @(negedge clk); while (out_req);
                repeat (pick_delay()) @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    // Compare each received result with the oldest expected one
    initial begin
        conv_t got;
        exp_t  e;
        num_checked = 0;
        forever begin
            @(negedge clk);
            while (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                if (exp_q.size() == 0) begin
                    $display("output without matching input, result %h", got.res);
                    $display("Test FAILED");
                    $fatal(1);
                end
                e        = exp_q.pop_front();
                cur_op   = e.op;
                cur_mode = e.mode;
                check_val("out_res", got.res, e.conv.res);
                check_val("out_invalid", {31'd0, got.invalid}, {31'd0, e.conv.invalid});
                check_val("out_inexact", {31'd0, got.inexact}, {31'd0, e.conv.inexact});
                num_checked++;
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, %0d of %0d results checked",
                 TIMEOUT_NS, num_checked, N_OPS);
        $display("Test FAILED");
        $fatal(1);
    end

    // Stimulus
    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] op;
        rst       = 1'b1;
        in_req    = 1'b0;
        in_op     = 32'd0;
        in_rmode  = RM_RNE;
        cur_op    = 32'd0;
        cur_mode  = RM_RNE;
        prod_seed = 32'heb58e2c3;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        // Every directed value under every mode
        for (int i = 0; i < N_DIR; i++) begin
            for (int m = 0; m < 4; m++) begin
                send_op(directed_op(i), rmode_e'(m));
            end
        end
        // Random stream, three in four biased toward the integer range
        for (int i = 0; i < N_RAND; i++) begin
            prod_seed = lcg_step(prod_seed);
            r1        = prod_seed;
            prod_seed = lcg_step(prod_seed);
            r2        = prod_seed;
            if (r1[17:16] == 2'd0) begin
                op = r2;
            end else begin
                op = {r2[31], 8'd110 + {2'b00, r1[29:24]}, r2[22:0]};
            end
            send_op(op, rmode_e'(r1[21:20]));
        end
        wait (num_checked == N_OPS);
        // Room for any stray extra output
        repeat (50) @(negedge clk);
        if (num_checked != N_OPS || exp_q.size() != 0 || rx_q.size() != 0) begin
            $display("Result count wrong, %0d checked of %0d, %0d still expected",
                     num_checked, N_OPS, exp_q.size());
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+bench
source/fcvt_pkg.sv
source/fcvt_in_port.sv
source/float_to_int.sv
source/fcvt_out_port.sv
source/fcvt_top.sv
bench/fcvt_tb.sv

/* Bender.yml */
package:
  name: fcvt

sources:
  # Design, package first
  - files:
      - source/fcvt_pkg.sv
      - source/fcvt_in_port.sv
      - source/float_to_int.sv
      - source/fcvt_out_port.sv
      - source/fcvt_top.sv

  # Testbench with the reference model header
  - target: test
    include_dirs:
      - bench
    files:
      - bench/fcvt_tb.sv
